// File: all.f
+incdir+verification
src/csr_pkg.sv
src/sys_decoder.sv
src/csr.sv
src/csr_unit_top.sv
verification/tb_csr_unit.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_csr_unit -f all.f -o sim_csr_unit
./obj_dir/sim_csr_unit

// File: src/csr.sv
// Machine-mode CSR file with trap entry and MRET
// csr_rd_o follows the address field every cycle, valid strobe or not
// irq_i levels are sampled only in cycles with instr_valid_i high
// On a trap, registers touched by the trap take the trap value over a CSR write

module csr #(
  parameter csr_pkg::rdata_t MTVEC_DEFAULT_VAL = 32'h0000_1000
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  instr_valid_i,
  input  logic                  stall_i,
  input  csr_pkg::s_sys_instr_t sys_i,
  input  csr_pkg::instr_t       instr_i,
  input  csr_pkg::pc_t          pc_i,
  input  csr_pkg::rdata_t       rs1_data_i,
  input  csr_pkg::s_irq_t       irq_i,
  output csr_pkg::rdata_t       csr_rd_o,
  output csr_pkg::s_trap_info_t trap_o
);

  localparam csr_pkg::rdata_t CAUSE_EXT_IRQ   = 32'h8000_000B;
  localparam csr_pkg::rdata_t CAUSE_SW_IRQ    = 32'h8000_0003;
  localparam csr_pkg::rdata_t CAUSE_TIMER_IRQ = 32'h8000_0007;
  localparam csr_pkg::rdata_t CAUSE_ILLEGAL   = 32'd2;
  localparam csr_pkg::rdata_t CAUSE_ECALL     = 32'd11;
  localparam csr_pkg::rdata_t CAUSE_EBREAK    = 32'd3;

  csr_pkg::rdata_t mstatus_ff, next_mstatus;
  csr_pkg::rdata_t mie_ff, next_mie;
  csr_pkg::rdata_t mtvec_ff, next_mtvec;
  csr_pkg::rdata_t mscratch_ff, next_mscratch;
  csr_pkg::rdata_t mepc_ff, next_mepc;
  csr_pkg::rdata_t mcause_ff, next_mcause;
  csr_pkg::rdata_t mtval_ff, next_mtval;
  csr_pkg::rdata_t mip_ff, next_mip;

  csr_pkg::rdata_ext_t   cycle_ff;
  csr_pkg::s_trap_info_t trap_ff, next_trap;

  csr_pkg::rdata_t wr_mask;
  csr_pkg::rdata_t wr_val;
  csr_pkg::rdata_t zimm_ext;
  logic            csr_writable;
  logic            rmw_keep;
  logic            csr_wr_en;

  logic            irq_en;
  logic            take_ext;
  logic            take_sw;
  logic            take_timer;
  logic            trap_taken;
  logic            do_mret;
  csr_pkg::rdata_t trap_cause;
  csr_pkg::rdata_t trap_mtval;
  csr_pkg::rdata_t irq_mip_bit;
  csr_pkg::rdata_t vec_offset;
  csr_pkg::pc_t    mtvec_base;

  function automatic csr_pkg::rdata_t csr_op_result(
    input csr_pkg::csr_op_t op,
    input csr_pkg::rdata_t  old_val,
    input csr_pkg::rdata_t  rs1_val,
    input csr_pkg::rdata_t  imm_val
  );
    csr_pkg::rdata_t res;
    case (op)
      csr_pkg::RV_CSR_RW:  res = rs1_val;
      csr_pkg::RV_CSR_RS:  res = old_val | rs1_val;
      csr_pkg::RV_CSR_RC:  res = old_val & ~rs1_val;
      csr_pkg::RV_CSR_RWI: res = imm_val;
      csr_pkg::RV_CSR_RSI: res = old_val | imm_val;
      csr_pkg::RV_CSR_RCI: res = old_val & ~imm_val;
      default:             res = old_val;
    endcase
    return res;
  endfunction

  // Read mux that also selects the write mask
  always_comb begin
    csr_rd_o     = '0;
    wr_mask      = '0;
    csr_writable = 1'b0;
    case (sys_i.csr.addr)
      csr_pkg::RV_CSR_MSTATUS: begin
        csr_rd_o     = mstatus_ff;
        wr_mask      = csr_pkg::MSTATUS_MASK;
        csr_writable = 1'b1;
      end
      csr_pkg::RV_CSR_MIE: begin
        csr_rd_o     = mie_ff;
        wr_mask      = csr_pkg::MIE_MASK;
        csr_writable = 1'b1;
      end
      csr_pkg::RV_CSR_MTVEC: begin
        csr_rd_o     = mtvec_ff;
        wr_mask      = csr_pkg::MTVEC_MASK;
        csr_writable = 1'b1;
      end
      csr_pkg::RV_CSR_MSCRATCH: begin
        csr_rd_o     = mscratch_ff;
        wr_mask      = '1;
        csr_writable = 1'b1;
      end
      csr_pkg::RV_CSR_MEPC: begin
        csr_rd_o     = mepc_ff;
        wr_mask      = csr_pkg::MEPC_MASK;
        csr_writable = 1'b1;
      end
      csr_pkg::RV_CSR_MTVAL: begin
        csr_rd_o     = mtval_ff;
        wr_mask      = '1;
        csr_writable = 1'b1;
      end
      csr_pkg::RV_CSR_MIP: begin
        csr_rd_o     = mip_ff;
        wr_mask      = csr_pkg::MIP_MASK;
        csr_writable = 1'b1;
      end
      csr_pkg::RV_CSR_MCAUSE:  csr_rd_o = mcause_ff;
      csr_pkg::RV_CSR_MISA:    csr_rd_o = csr_pkg::MISA_VAL;
      csr_pkg::RV_CSR_CYCLE:   csr_rd_o = cycle_ff[31:0];
      csr_pkg::RV_CSR_CYCLEH:  csr_rd_o = cycle_ff[63:32];
      csr_pkg::RV_CSR_MHARTID: csr_rd_o = csr_pkg::HART_ID;
      default:                 csr_rd_o = '0;
    endcase
  end

  assign zimm_ext = csr_pkg::rdata_t'(sys_i.zimm);
  assign wr_val   = csr_op_result(sys_i.csr.op, csr_rd_o, rs1_data_i, zimm_ext) & wr_mask;

  // Set and clear forms with rs1 = x0 are pure reads
  assign rmw_keep  = sys_i.csr.rs1_is_x0 &&
                     (sys_i.csr.op != csr_pkg::RV_CSR_RW) &&
                     (sys_i.csr.op != csr_pkg::RV_CSR_RWI);
  assign csr_wr_en = instr_valid_i && (sys_i.csr.op != csr_pkg::RV_CSR_NONE) &&
                     !stall_i && csr_writable && !rmw_keep;

  // Interrupts need the global enable plus their own mie bit
  assign irq_en     = instr_valid_i && mstatus_ff[csr_pkg::MST_MIE];
  assign take_ext   = irq_en && irq_i.ext_irq && mie_ff[csr_pkg::MIE_MEIP];
  assign take_sw    = irq_en && irq_i.sw_irq && mie_ff[csr_pkg::MIE_MSIP];
  assign take_timer = irq_en && irq_i.timer_irq && mie_ff[csr_pkg::MIE_MTIP];

  // Fixed priority with interrupts first
  always_comb begin
    trap_taken  = 1'b1;
    trap_cause  = '0;
    trap_mtval  = '0;
    irq_mip_bit = '0;
    vec_offset  = '0;
    if (take_ext) begin
      trap_cause                      = CAUSE_EXT_IRQ;
      irq_mip_bit[csr_pkg::MIE_MEIP]  = 1'b1;
      vec_offset                      = 32'h2C;
    end else if (take_sw) begin
      trap_cause                      = CAUSE_SW_IRQ;
      irq_mip_bit[csr_pkg::MIE_MSIP]  = 1'b1;
      vec_offset                      = 32'h0C;
    end else if (take_timer) begin
      trap_cause                      = CAUSE_TIMER_IRQ;
      irq_mip_bit[csr_pkg::MIE_MTIP]  = 1'b1;
      vec_offset                      = 32'h1C;
    end else if (instr_valid_i && sys_i.illegal) begin
      trap_cause = CAUSE_ILLEGAL;
      trap_mtval = instr_i;
    end else if (instr_valid_i && sys_i.ecall) begin
      trap_cause = CAUSE_ECALL;
    end else if (instr_valid_i && sys_i.ebreak) begin
      trap_cause = CAUSE_EBREAK;
    end else begin
      trap_taken = 1'b0;
    end
  end

  assign do_mret    = instr_valid_i && sys_i.mret && !trap_taken;
  assign mtvec_base = {mtvec_ff[csr_pkg::XLEN-1:2], 2'b00};

  always_comb begin
    next_mstatus  = mstatus_ff;
    next_mie      = mie_ff;
    next_mtvec    = mtvec_ff;
    next_mscratch = mscratch_ff;
    next_mepc     = mepc_ff;
    next_mcause   = mcause_ff;
    next_mtval    = mtval_ff;
    next_mip      = mip_ff;
    next_trap     = '0;

    if (csr_wr_en) begin
      case (sys_i.csr.addr)
        csr_pkg::RV_CSR_MSTATUS:  next_mstatus  = wr_val;
        csr_pkg::RV_CSR_MIE:      next_mie      = wr_val;
        csr_pkg::RV_CSR_MTVEC:    next_mtvec    = wr_val;
        csr_pkg::RV_CSR_MSCRATCH: next_mscratch = wr_val;
        csr_pkg::RV_CSR_MEPC:     next_mepc     = wr_val;
        csr_pkg::RV_CSR_MTVAL:    next_mtval    = wr_val;
        csr_pkg::RV_CSR_MIP:      next_mip      = wr_val;
        default: ;
      endcase
    end

    if (trap_taken) begin
      next_mepc   = {pc_i[csr_pkg::XLEN-1:2], 2'b00};
      next_mcause = trap_cause;
      next_mtval  = trap_mtval;
      if (|irq_mip_bit) begin
        next_mip = mip_ff | irq_mip_bit;
      end
      // Push the interrupt enable stack
      next_mstatus                    = mstatus_ff;
      next_mstatus[csr_pkg::MST_MPIE] = mstatus_ff[csr_pkg::MST_MIE];
      next_mstatus[csr_pkg::MST_MIE]  = 1'b0;
      next_trap.active  = 1'b1;
      next_trap.pc_addr = mtvec_ff[0] ? (mtvec_base + vec_offset) : mtvec_base;
      next_trap.mtval   = trap_mtval;
    end else if (do_mret) begin
      // Pop the stack and leave MPIE set
      next_mstatus                    = mstatus_ff;
      next_mstatus[csr_pkg::MST_MIE]  = mstatus_ff[csr_pkg::MST_MPIE];
      next_mstatus[csr_pkg::MST_MPIE] = 1'b1;
      next_trap.active  = 1'b1;
      next_trap.pc_addr = mepc_ff;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      mstatus_ff  <= csr_pkg::MSTATUS_RST;
      mie_ff      <= '0;
      mtvec_ff    <= MTVEC_DEFAULT_VAL;
      mscratch_ff <= '0;
      mepc_ff     <= '0;
      mcause_ff   <= '0;
      mtval_ff    <= '0;
      mip_ff      <= '0;
      cycle_ff    <= '0;
      trap_ff     <= '0;
    end else begin
      mstatus_ff  <= next_mstatus;
      mie_ff      <= next_mie;
      mtvec_ff    <= next_mtvec;
      mscratch_ff <= next_mscratch;
      mepc_ff     <= next_mepc;
      mcause_ff   <= next_mcause;
      mtval_ff    <= next_mtval;
      mip_ff      <= next_mip;
      cycle_ff    <= cycle_ff + 64'd1;
      trap_ff     <= next_trap;
    end
  end

  // One-cycle pulse after the deciding edge
  assign trap_o = trap_ff;

endmodule

// File: src/csr_pkg.sv
// Shared types and constants for the machine-mode CSR and trap unit
// RV32 only, single hart, machine mode only
// Addresses outside csr_addr_t still travel in the enum field and read as 0

package csr_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0]   rdata_t;
  typedef logic [2*XLEN-1:0] rdata_ext_t;
  typedef logic [XLEN-1:0]   pc_t;
  typedef logic [XLEN-1:0]   instr_t;

  // Matches funct3 of the SYSTEM opcode
  typedef enum logic [2:0] {
    RV_CSR_NONE = 3'd0,
    RV_CSR_RW   = 3'd1,
    RV_CSR_RS   = 3'd2,
    RV_CSR_RC   = 3'd3,
    RV_CSR_RWI  = 3'd5,
    RV_CSR_RSI  = 3'd6,
    RV_CSR_RCI  = 3'd7
  } csr_op_t;

  typedef enum logic [11:0] {
    RV_CSR_MSTATUS  = 12'h300,
    RV_CSR_MISA     = 12'h301,
    RV_CSR_MIE      = 12'h304,
    RV_CSR_MTVEC    = 12'h305,
    RV_CSR_MSCRATCH = 12'h340,
    RV_CSR_MEPC     = 12'h341,
    RV_CSR_MCAUSE   = 12'h342,
    RV_CSR_MTVAL    = 12'h343,
    RV_CSR_MIP      = 12'h344,
    RV_CSR_CYCLE    = 12'hC00,
    RV_CSR_CYCLEH   = 12'hC80,
    RV_CSR_MHARTID  = 12'hF14
  } csr_addr_t;

  typedef struct packed {
    csr_op_t   op;
    csr_addr_t addr;
    logic      rs1_is_x0;
  } s_csr_t;

  typedef struct packed {
    s_csr_t     csr;
    logic [4:0] zimm;
    logic       ecall;
    logic       ebreak;
    logic       mret;
    logic       illegal;
  } s_sys_instr_t;

  // Level interrupt lines, already in the core clock domain
  typedef struct packed {
    logic ext_irq;
    logic sw_irq;
    logic timer_irq;
  } s_irq_t;

  typedef struct packed {
    logic   active;
    pc_t    pc_addr;
    rdata_t mtval;
  } s_trap_info_t;

  // Writable bits per register
  localparam rdata_t MSTATUS_MASK = 32'h807F_F9BB;
  localparam rdata_t MIE_MASK     = 32'h0000_0888;
  localparam rdata_t MTVEC_MASK   = 32'hFFFF_FFFD;
  localparam rdata_t MEPC_MASK    = 32'hFFFF_FFFC;
  localparam rdata_t MIP_MASK     = 32'h0000_0008;

  // Reset and identity values
  localparam rdata_t MSTATUS_RST = 32'h0000_1880;
  localparam rdata_t MISA_VAL    = 32'h4000_0100;
  localparam rdata_t HART_ID     = 32'h0000_0000;

  // Bit positions in mstatus, mie and mip
  localparam int MST_MIE  = 3;
  localparam int MST_MPIE = 7;
  localparam int MIE_MSIP = 3;
  localparam int MIE_MTIP = 7;
  localparam int MIE_MEIP = 11;

endpackage

// File: src/csr_unit_top.sv
// Top level of the CSR and trap unit
// Expects a one-cycle instr_valid_i per retired SYSTEM instruction
// irq_i must already be synchronous to clk

module csr_unit_top #(
  parameter csr_pkg::rdata_t MTVEC_DEFAULT_VAL = 32'h0000_1000
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  instr_valid_i,
  input  csr_pkg::instr_t       instr_i,
  input  csr_pkg::pc_t          pc_i,
  input  csr_pkg::rdata_t       rs1_data_i,
  input  csr_pkg::s_irq_t       irq_i,
  input  logic                  stall_i,
  output csr_pkg::rdata_t       csr_rd_o,
  output csr_pkg::s_trap_info_t trap_o
);

  csr_pkg::s_sys_instr_t sys;

  sys_decoder u_sys_decoder (
    .instr_i (instr_i),
    .sys_o   (sys)
  );

  // Decoded word plus raw word, the latter feeds mtval
  csr #(
    .MTVEC_DEFAULT_VAL (MTVEC_DEFAULT_VAL)
  ) u_csr (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .stall_i       (stall_i),
    .sys_i         (sys),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .rs1_data_i    (rs1_data_i),
    .irq_i         (irq_i),
    .csr_rd_o      (csr_rd_o),
    .trap_o        (trap_o)
  );

endmodule

// File: src/sys_decoder.sv
// Combinational decode of one SYSTEM instruction word
// WFI and other funct12 values with funct3 zero are flagged illegal
// Address, rs1_is_x0 and zimm are plain field extracts for any word

module sys_decoder (
  input  csr_pkg::instr_t       instr_i,
  output csr_pkg::s_sys_instr_t sys_o
);

  localparam logic [6:0]  OPC_SYSTEM = 7'h73;
  localparam logic [11:0] F12_ECALL  = 12'h000;
  localparam logic [11:0] F12_EBREAK = 12'h001;
  localparam logic [11:0] F12_MRET   = 12'h302;

  logic [6:0]  opcode;
  logic [4:0]  rd_idx;
  logic [2:0]  funct3;
  logic [4:0]  rs1_idx;
  logic [11:0] funct12;
  logic        is_system;
  logic        priv_regs_zero;

  // Standard I-type field split
  assign opcode  = instr_i[6:0];
  assign rd_idx  = instr_i[11:7];
  assign funct3  = instr_i[14:12];
  assign rs1_idx = instr_i[19:15];
  assign funct12 = instr_i[31:20];

  assign is_system      = (opcode == OPC_SYSTEM);
  assign priv_regs_zero = (rd_idx == 5'd0) && (rs1_idx == 5'd0);

  always_comb begin
    sys_o = '0;

    // CSR read path uses these even when no write follows
    sys_o.csr.op        = csr_pkg::RV_CSR_NONE;
    sys_o.csr.addr      = csr_pkg::csr_addr_t'(funct12);
    sys_o.csr.rs1_is_x0 = (rs1_idx == 5'd0);
    sys_o.zimm          = rs1_idx;

    if (is_system) begin
      case (funct3)
        3'd0: begin
          // Privileged group, rd and rs1 must be x0
          if (priv_regs_zero && (funct12 == F12_ECALL)) begin
            sys_o.ecall = 1'b1;
          end else if (priv_regs_zero && (funct12 == F12_EBREAK)) begin
            sys_o.ebreak = 1'b1;
          end else if (priv_regs_zero && (funct12 == F12_MRET)) begin
            sys_o.mret = 1'b1;
          end else begin
            sys_o.illegal = 1'b1;
          end
        end
        3'd4: begin
          // Reserved funct3
          sys_o.illegal = 1'b1;
        end
        default: begin
          sys_o.csr.op = csr_pkg::csr_op_t'(funct3);
        end
      endcase
    end
  end

endmodule

// File: verification/csr_model.svh
// Reference model of the CSR and trap unit, included inside the testbench module
// Decodes the raw word itself and advances one clock edge per step_model call
// Expects MTVEC_VAL to be declared by the including module
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

csr_pkg::rdata_t       m_mstatus;
csr_pkg::rdata_t       m_mie;
csr_pkg::rdata_t       m_mtvec;
csr_pkg::rdata_t       m_mscratch;
csr_pkg::rdata_t       m_mepc;
csr_pkg::rdata_t       m_mcause;
csr_pkg::rdata_t       m_mtval;
csr_pkg::rdata_t       m_mip;
csr_pkg::rdata_ext_t   m_cycle;
csr_pkg::s_trap_info_t m_trap;

task automatic reset_model();
  m_mstatus  = csr_pkg::MSTATUS_RST;
  m_mie      = '0;
  m_mtvec    = MTVEC_VAL;
  m_mscratch = '0;
  m_mepc     = '0;
  m_mcause   = '0;
  m_mtval    = '0;
  m_mip      = '0;
  m_cycle    = '0;
  m_trap     = '0;
endtask

function automatic csr_pkg::rdata_t expected_rdata(input logic [11:0] addr);
  case (addr)
    12'h300: return m_mstatus;
    12'h301: return csr_pkg::MISA_VAL;
    12'h304: return m_mie;
    12'h305: return m_mtvec;
    12'h340: return m_mscratch;
    12'h341: return m_mepc;
    12'h342: return m_mcause;
    12'h343: return m_mtval;
    12'h344: return m_mip;
    12'hC00: return m_cycle[31:0];
    12'hC80: return m_cycle[63:32];
    12'hF14: return csr_pkg::HART_ID;
    default: return '0;
  endcase
endfunction

// Zero mask marks a read-only or unknown address
function automatic csr_pkg::rdata_t writable_mask(input logic [11:0] addr);
  case (addr)
    12'h300: return csr_pkg::MSTATUS_MASK;
    12'h304: return csr_pkg::MIE_MASK;
    12'h305: return csr_pkg::MTVEC_MASK;
    12'h340: return '1;
    12'h341: return csr_pkg::MEPC_MASK;
    12'h343: return '1;
    12'h344: return csr_pkg::MIP_MASK;
    default: return '0;
  endcase
endfunction

task automatic step_model(input logic valid, input csr_pkg::instr_t instr,
                          input csr_pkg::pc_t pc, input csr_pkg::rdata_t rs1_data,
                          input csr_pkg::s_irq_t irq, input logic stall);
  logic [2:0]      f3;
  logic [11:0]     f12;
  logic [4:0]      rs1;
  logic            sys;
  logic            priv0;
  logic            is_op;
  logic            ecall;
  logic            ebreak;
  logic            mret;
  logic            illegal;
  logic            irq_on;
  logic            trap;
  csr_pkg::rdata_t src;
  csr_pkg::rdata_t res;
  csr_pkg::rdata_t old_mstatus;
  csr_pkg::rdata_t old_mie;
  csr_pkg::rdata_t old_mtvec;
  csr_pkg::rdata_t old_mepc;
  csr_pkg::rdata_t old_mip;
  csr_pkg::rdata_t cause;
  csr_pkg::rdata_t tval;
  csr_pkg::rdata_t bit_set;
  csr_pkg::rdata_t offs;

  f3      = instr[14:12];
  f12     = instr[31:20];
  rs1     = instr[19:15];
  sys     = (instr[6:0] == 7'h73);
  priv0   = (instr[11:7] == 5'd0) && (rs1 == 5'd0);
  ecall   = sys && (f3 == 3'd0) && priv0 && (f12 == 12'h000);
  ebreak  = sys && (f3 == 3'd0) && priv0 && (f12 == 12'h001);
  mret    = sys && (f3 == 3'd0) && priv0 && (f12 == 12'h302);
  illegal = sys && (((f3 == 3'd0) && !(ecall || ebreak || mret)) || (f3 == 3'd4));
  is_op   = sys && (f3 != 3'd0) && (f3 != 3'd4);

  old_mstatus = m_mstatus;
  old_mie     = m_mie;
  old_mtvec   = m_mtvec;
  old_mepc    = m_mepc;
  old_mip     = m_mip;

  // Immediate forms use the rs1 field as data
  src = f3[2] ? {27'd0, rs1} : rs1_data;
  case (f3[1:0])
    2'd1:    res = src;
    2'd2:    res = expected_rdata(f12) | src;
    default: res = expected_rdata(f12) & ~src;
  endcase
  if (valid && is_op && !stall && (writable_mask(f12) != '0) &&
      ((rs1 != 5'd0) || (f3[1:0] == 2'd1))) begin
    res = res & writable_mask(f12);
    case (f12)
      12'h300: m_mstatus  = res;
      12'h304: m_mie      = res;
      12'h305: m_mtvec    = res;
      12'h340: m_mscratch = res;
      12'h341: m_mepc     = res;
      12'h343: m_mtval    = res;
      12'h344: m_mip      = res;
      default: ;
    endcase
  end

  irq_on  = valid && old_mstatus[csr_pkg::MST_MIE];
  trap    = 1'b1;
  cause   = '0;
  tval    = '0;
  bit_set = '0;
  offs    = '0;
  if (irq_on && irq.ext_irq && old_mie[csr_pkg::MIE_MEIP]) begin
    cause                     = 32'h8000_000B;
    bit_set[csr_pkg::MIE_MEIP] = 1'b1;
    offs                      = 32'h2C;
  end else if (irq_on && irq.sw_irq && old_mie[csr_pkg::MIE_MSIP]) begin
    cause                     = 32'h8000_0003;
    bit_set[csr_pkg::MIE_MSIP] = 1'b1;
    offs                      = 32'h0C;
  end else if (irq_on && irq.timer_irq && old_mie[csr_pkg::MIE_MTIP]) begin
    cause                     = 32'h8000_0007;
    bit_set[csr_pkg::MIE_MTIP] = 1'b1;
    offs                      = 32'h1C;
  end else if (valid && illegal) begin
    cause = 32'd2;
    tval  = instr;
  end else if (valid && ecall) begin
    cause = 32'd11;
  end else if (valid && ebreak) begin
    cause = 32'd3;
  end else begin
    trap = 1'b0;
  end

  m_trap = '0;
  if (trap) begin
    m_mepc   = {pc[31:2], 2'b00};
    m_mcause = cause;
    m_mtval  = tval;
    if (bit_set != '0) begin
      m_mip = old_mip | bit_set;
    end
    m_mstatus                    = old_mstatus;
    m_mstatus[csr_pkg::MST_MPIE] = old_mstatus[csr_pkg::MST_MIE];
    m_mstatus[csr_pkg::MST_MIE]  = 1'b0;
    m_trap.active  = 1'b1;
    m_trap.pc_addr = {old_mtvec[31:2], 2'b00} + (old_mtvec[0] ? offs : 32'd0);
    m_trap.mtval   = tval;
  end else if (valid && mret) begin
    m_mstatus                    = old_mstatus;
    m_mstatus[csr_pkg::MST_MIE]  = old_mstatus[csr_pkg::MST_MPIE];
    m_mstatus[csr_pkg::MST_MPIE] = 1'b1;
    m_trap.active  = 1'b1;
    m_trap.pc_addr = old_mepc;
  end
  m_cycle = m_cycle + 64'd1;
endtask

`endif

// File: verification/tb_csr_unit.sv
// Testbench for the CSR and trap unit
// Directed reset reads and interrupt entry first, then seeded random cycles
// Inputs change 5 ns after the rising edge
// Outputs are sampled mid-cycle

module tb_csr_unit;
  timeunit 1ns;
  timeprecision 1ps;

  localparam csr_pkg::rdata_t MTVEC_VAL    = 32'h0000_0800;
  localparam int              CLK_PERIOD   = 100;
  localparam int              RESET_CYCLES = 10;
  localparam int              NUM_DIRECTED = 25;
  localparam int              NUM_RANDOM   = 3000;
  localparam logic [31:0]     SEED         = 32'h1d89ce8f;

  localparam logic [11:0] ADDR_LIST [12] = '{12'h300, 12'h301, 12'h304, 12'h305,
                                             12'h340, 12'h341, 12'h342, 12'h343,
                                             12'h344, 12'hC00, 12'hC80, 12'hF14};
  localparam logic [2:0]  OP_LIST [6]    = '{3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7};

  logic                  clk;
  logic                  rst_n_i;
  logic                  instr_valid_i;
  csr_pkg::instr_t       instr_i;
  csr_pkg::pc_t          pc_i;
  csr_pkg::rdata_t       rs1_data_i;
  csr_pkg::s_irq_t       irq_i;
  logic                  stall_i;
  csr_pkg::rdata_t       csr_rd_o;
  csr_pkg::s_trap_info_t trap_o;

  `include "csr_model.svh"

  csr_unit_top #(
    .MTVEC_DEFAULT_VAL (MTVEC_VAL)
  ) uut (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .rs1_data_i    (rs1_data_i),
    .irq_i         (irq_i),
    .stall_i       (stall_i),
    .csr_rd_o      (csr_rd_o),
    .trap_o        (trap_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((RESET_CYCLES + NUM_DIRECTED + NUM_RANDOM + 20) * CLK_PERIOD);
    $display("Watchdog expired before the test sequence finished");
    $display("Test failed");
    $fatal(1, "Simulation timeout");
  end

  function automatic csr_pkg::instr_t sys_word(input logic [11:0] f12, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd);
    return {f12, rs1, f3, rd, 7'h73};
  endfunction

  task automatic check_rdata(input string name, input csr_pkg::rdata_t exp,
                             input csr_pkg::rdata_t act);
    if (act !== exp) begin
      $display("Mismatch %s csr_rd_o expected %h actual %h", name, exp, act);
      $display("Test failed");
      $fatal(1, "csr_rd_o check");
    end
  endtask

  task automatic check_trap(input string name, input csr_pkg::s_trap_info_t exp,
                            input csr_pkg::s_trap_info_t act);
    if (act !== exp) begin
      $display("Mismatch %s trap_o expected %h actual %h", name, exp, act);
      $display("Test failed");
      $fatal(1, "trap_o check");
    end
  endtask

  // Runs from one rising edge to the next
  task automatic run_cycle(input string name, input logic valid, input csr_pkg::instr_t instr,
                           input csr_pkg::pc_t pc, input csr_pkg::rdata_t rs1,
                           input csr_pkg::s_irq_t irq, input logic stall);
    #5;
    // Reset release rides along with the first stimulus
    rst_n_i       = 1'b1;
    instr_valid_i = valid;
    instr_i       = instr;
    pc_i          = pc;
    rs1_data_i    = rs1;
    irq_i         = irq;
    stall_i       = stall;
    #40;
    check_rdata(name, expected_rdata(instr[31:20]), csr_rd_o);
    check_trap(name, m_trap, trap_o);
    step_model(valid, instr, pc, rs1, irq, stall);
    @(posedge clk);
  endtask

  initial begin
    int unsigned     kind;
    logic [31:0]     r;
    logic [4:0]      rs1;
    logic [11:0]     addr;
    csr_pkg::instr_t word;
    csr_pkg::s_irq_t irq;
    string           kname;

    void'($urandom(SEED));
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    rs1_data_i    = '0;
    irq_i         = '0;
    stall_i       = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset_model();

    for (int i = 0; i < 12; i++) begin
      run_cycle("reset_read", 1'b0, sys_word(ADDR_LIST[i], 5'd0, 3'd2, 5'd0), '0, '0, '0, 1'b0);
    end
    run_cycle("reset_read", 1'b0, sys_word(12'h7C0, 5'd0, 3'd2, 5'd0), '0, '0, '0, 1'b0);

    // Vectored mtvec, all mie bits, then global enable
    run_cycle("irq_setup", 1'b1, sys_word(12'h305, 5'd5, 3'd1, 5'd1), 32'h100, 32'h4001, '0, 1'b0);
    run_cycle("irq_setup", 1'b1, sys_word(12'h304, 5'd5, 3'd1, 5'd1), 32'h104, 32'h888, '0, 1'b0);
    run_cycle("irq_setup", 1'b1, sys_word(12'h300, 5'd5, 3'd2, 5'd1), 32'h108, 32'h8, '0, 1'b0);
    run_cycle("irq_ext", 1'b1, sys_word(12'h000, 5'd0, 3'd0, 5'd0), 32'h10E, '0, 3'b111, 1'b0);
    run_cycle("irq_ext", 1'b0, sys_word(12'h342, 5'd0, 3'd2, 5'd1), '0, '0, '0, 1'b0);
    run_cycle("mret", 1'b1, sys_word(12'h302, 5'd0, 3'd0, 5'd0), 32'h4030, '0, '0, 1'b0);
    run_cycle("irq_sw", 1'b1, sys_word(12'h000, 5'd0, 3'd0, 5'd0), 32'h200, '0, 3'b011, 1'b0);
    run_cycle("irq_sw", 1'b0, sys_word(12'h344, 5'd0, 3'd2, 5'd1), '0, '0, '0, 1'b0);
    run_cycle("mret", 1'b1, sys_word(12'h302, 5'd0, 3'd0, 5'd0), 32'h4010, '0, '0, 1'b0);
    run_cycle("irq_timer", 1'b1, sys_word(12'h123, 5'd3, 3'd4, 5'd2), 32'h300, '0, 3'b001, 1'b0);
    run_cycle("irq_timer", 1'b0, sys_word(12'h341, 5'd0, 3'd2, 5'd1), '0, '0, '0, 1'b0);
    run_cycle("mret", 1'b1, sys_word(12'h302, 5'd0, 3'd0, 5'd0), 32'h4020, '0, '0, 1'b0);

    for (int n = 0; n < NUM_RANDOM; n++) begin
      kind = $urandom % 10;
      r    = $urandom;
      rs1  = (r[2:0] == 3'd0) ? 5'd0 : r[7:3];
      addr = (r[15:14] != 2'b00) ? ADDR_LIST[$urandom % 12] : r[31:20];
      case (kind)
        5: begin
          word  = sys_word(12'h000, 5'd0, 3'd0, 5'd0);
          kname = "random_ecall";
        end
        6: begin
          word  = sys_word(12'h001, 5'd0, 3'd0, 5'd0);
          kname = "random_ebreak";
        end
        7: begin
          word  = sys_word(12'h302, 5'd0, 3'd0, 5'd0);
          kname = "random_mret";
        end
        8: begin
          word  = sys_word(r[31:20], rs1, r[13] ? 3'd4 : 3'd0, r[12:8]);
          kname = "random_illegal";
        end
        9: begin
          word  = {r[31:7], 7'h33};
          kname = "random_other";
        end
        default: begin
          word  = sys_word(addr, rs1, OP_LIST[$urandom % 6], r[12:8]);
          kname = "random_csr";
        end
      endcase
      irq.ext_irq   = ($urandom % 100) < 5;
      irq.sw_irq    = ($urandom % 100) < 5;
      irq.timer_irq = ($urandom % 100) < 5;
      run_cycle(kname, ($urandom % 100) < 70, word, $urandom, $urandom, irq,
                ($urandom % 100) < 10);
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule
